// File: reservation_station.sv
module reservation_station (
    input  logic                                        clock,
    input  logic                                        reset,
    input  rs_pkg::way_mask_t                           disp_load,
    input  rs_pkg::data_t [rs_pkg::NUM_WAYS-1:0]        disp_opa,
    input  rs_pkg::data_t [rs_pkg::NUM_WAYS-1:0]        disp_opb,
    input  rs_pkg::way_mask_t                           disp_opa_ready,
    input  rs_pkg::way_mask_t                           disp_opb_ready,
    input  rs_pkg::prf_idx_t [rs_pkg::NUM_WAYS-1:0]     disp_dest_idx,
    input  rs_pkg::rob_idx_t [rs_pkg::NUM_WAYS-1:0]     disp_rob_idx,
    input  rs_pkg::pc_t [rs_pkg::NUM_WAYS-1:0]          disp_pc,
    input  rs_pkg::offset_t [rs_pkg::NUM_WAYS-1:0]      disp_offset,
    input  rs_pkg::alu_func_t [rs_pkg::NUM_WAYS-1:0]    disp_func,
    input  rs_pkg::way_mask_t                           disp_rd_mem,
    input  rs_pkg::way_mask_t                           disp_wr_mem,
    input  rs_pkg::way_mask_t                           cdb_valid,
    input  rs_pkg::prf_idx_t [rs_pkg::NUM_WAYS-1:0]     cdb_tag,
    input  rs_pkg::data_t [rs_pkg::NUM_WAYS-1:0]        cdb_data,
    output rs_pkg::way_mask_t                           disp_accept,
    output rs_pkg::free_count_t                         free_count,
    output rs_pkg::way_mask_t                           issue_valid,
    output rs_pkg::data_t [rs_pkg::NUM_WAYS-1:0]        issue_opa,
    output rs_pkg::data_t [rs_pkg::NUM_WAYS-1:0]        issue_opb,
    output rs_pkg::prf_idx_t [rs_pkg::NUM_WAYS-1:0]     issue_dest_idx,
    output rs_pkg::rob_idx_t [rs_pkg::NUM_WAYS-1:0]     issue_rob_idx,
    output rs_pkg::pc_t [rs_pkg::NUM_WAYS-1:0]          issue_pc,
    output rs_pkg::offset_t [rs_pkg::NUM_WAYS-1:0]      issue_offset,
    output rs_pkg::alu_func_t [rs_pkg::NUM_WAYS-1:0]    issue_func,
    output rs_pkg::way_mask_t                           issue_rd_mem,
    output rs_pkg::way_mask_t                           issue_wr_mem
);
    import rs_pkg::*;

    entry_mask_t                entry_free;
    entry_mask_t                entry_ready;
    entry_mask_t                entry_load;
    entry_mask_t                entry_issue;
    free_count_t                issue_count;

    // steered dispatch fields, allocator to entries
    data_t [RS_SIZE-1:0]        load_opa;
    data_t [RS_SIZE-1:0]        load_opb;
    entry_mask_t                load_opa_ready;
    entry_mask_t                load_opb_ready;
    prf_idx_t [RS_SIZE-1:0]     load_dest_idx;
    rob_idx_t [RS_SIZE-1:0]     load_rob_idx;
    pc_t [RS_SIZE-1:0]          load_pc;
    offset_t [RS_SIZE-1:0]      load_offset;
    alu_func_t [RS_SIZE-1:0]    load_func;
    entry_mask_t                load_rd_mem;
    entry_mask_t                load_wr_mem;

    // stored fields, entries to selector
    data_t [RS_SIZE-1:0]        entry_opa;
    data_t [RS_SIZE-1:0]        entry_opb;
    prf_idx_t [RS_SIZE-1:0]     entry_dest_idx;
    rob_idx_t [RS_SIZE-1:0]     entry_rob_idx;
    pc_t [RS_SIZE-1:0]          entry_pc;
    offset_t [RS_SIZE-1:0]      entry_offset;
    alu_func_t [RS_SIZE-1:0]    entry_func;
    entry_mask_t                entry_rd_mem;
    entry_mask_t                entry_wr_mem;

    rs_alloc alloc_inst (
        .clock, .reset,
        .disp_load, .disp_opa, .disp_opb, .disp_opa_ready, .disp_opb_ready,
        .disp_dest_idx, .disp_rob_idx, .disp_pc, .disp_offset, .disp_func,
        .disp_rd_mem, .disp_wr_mem,
        .cdb_valid, .cdb_tag, .cdb_data,
        .entry_free, .issue_count,
        .disp_accept, .free_count, .entry_load,
        .load_opa, .load_opb, .load_opa_ready, .load_opb_ready,
        .load_dest_idx, .load_rob_idx, .load_pc, .load_offset, .load_func,
        .load_rd_mem, .load_wr_mem
    );

    rs_entry entries [RS_SIZE-1:0] (
        .clock        (clock),
        .reset        (reset),
        .load         (entry_load),
        .issue        (entry_issue),
        .opa_in       (load_opa),
        .opb_in       (load_opb),
        .opa_ready_in (load_opa_ready),
        .opb_ready_in (load_opb_ready),
        .dest_idx_in  (load_dest_idx),
        .rob_idx_in   (load_rob_idx),
        .pc_in        (load_pc),
        .offset_in    (load_offset),
        .func_in      (load_func),
        .rd_mem_in    (load_rd_mem),
        .wr_mem_in    (load_wr_mem),
        .cdb_valid    (cdb_valid),     // broadcast to every entry
        .cdb_tag      (cdb_tag),
        .cdb_data     (cdb_data),
        .is_free      (entry_free),
        .ready        (entry_ready),
        .opa_out      (entry_opa),
        .opb_out      (entry_opb),
        .dest_idx_out (entry_dest_idx),
        .rob_idx_out  (entry_rob_idx),
        .pc_out       (entry_pc),
        .offset_out   (entry_offset),
        .func_out     (entry_func),
        .rd_mem_out   (entry_rd_mem),
        .wr_mem_out   (entry_wr_mem)
    );

    rs_issue_select select_inst (
        .entry_ready, .entry_opa, .entry_opb, .entry_dest_idx, .entry_rob_idx,
        .entry_pc, .entry_offset, .entry_func, .entry_rd_mem, .entry_wr_mem,
        .entry_issue, .issue_count,
        .issue_valid, .issue_opa, .issue_opb, .issue_dest_idx, .issue_rob_idx,
        .issue_pc, .issue_offset, .issue_func, .issue_rd_mem, .issue_wr_mem
    );

endmodule

// File: rs_alloc.sv
module rs_alloc (
    input  logic                                        clock,
    input  logic                                        reset,
    input  rs_pkg::way_mask_t                           disp_load,
    input  rs_pkg::data_t [rs_pkg::NUM_WAYS-1:0]        disp_opa,
    input  rs_pkg::data_t [rs_pkg::NUM_WAYS-1:0]        disp_opb,
    input  rs_pkg::way_mask_t                           disp_opa_ready,
    input  rs_pkg::way_mask_t                           disp_opb_ready,
    input  rs_pkg::prf_idx_t [rs_pkg::NUM_WAYS-1:0]     disp_dest_idx,
    input  rs_pkg::rob_idx_t [rs_pkg::NUM_WAYS-1:0]     disp_rob_idx,
    input  rs_pkg::pc_t [rs_pkg::NUM_WAYS-1:0]          disp_pc,
    input  rs_pkg::offset_t [rs_pkg::NUM_WAYS-1:0]      disp_offset,
    input  rs_pkg::alu_func_t [rs_pkg::NUM_WAYS-1:0]    disp_func,
    input  rs_pkg::way_mask_t                           disp_rd_mem,
    input  rs_pkg::way_mask_t                           disp_wr_mem,
    input  rs_pkg::way_mask_t                           cdb_valid,
    input  rs_pkg::prf_idx_t [rs_pkg::NUM_WAYS-1:0]     cdb_tag,
    input  rs_pkg::data_t [rs_pkg::NUM_WAYS-1:0]        cdb_data,
    input  rs_pkg::entry_mask_t                         entry_free,
    input  rs_pkg::free_count_t                         issue_count,
    output rs_pkg::way_mask_t                           disp_accept,
    output rs_pkg::free_count_t                         free_count,
    output rs_pkg::entry_mask_t                         entry_load,
    output rs_pkg::data_t [rs_pkg::RS_SIZE-1:0]         load_opa,
    output rs_pkg::data_t [rs_pkg::RS_SIZE-1:0]         load_opb,
    output rs_pkg::entry_mask_t                         load_opa_ready,
    output rs_pkg::entry_mask_t                         load_opb_ready,
    output rs_pkg::prf_idx_t [rs_pkg::RS_SIZE-1:0]      load_dest_idx,
    output rs_pkg::rob_idx_t [rs_pkg::RS_SIZE-1:0]      load_rob_idx,
    output rs_pkg::pc_t [rs_pkg::RS_SIZE-1:0]           load_pc,
    output rs_pkg::offset_t [rs_pkg::RS_SIZE-1:0]       load_offset,
    output rs_pkg::alu_func_t [rs_pkg::RS_SIZE-1:0]     load_func,
    output rs_pkg::entry_mask_t                         load_rd_mem,
    output rs_pkg::entry_mask_t                         load_wr_mem
);
    import rs_pkg::*;

    data_t [NUM_WAYS-1:0] byp_opa;
    data_t [NUM_WAYS-1:0] byp_opb;
    way_mask_t            byp_opa_ready;
    way_mask_t            byp_opb_ready;
    free_count_t          accept_count;

    // catch a tag broadcast in the dispatch cycle itself
    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            byp_opa[w]       = disp_opa[w];
            byp_opb[w]       = disp_opb[w];
            byp_opa_ready[w] = disp_opa_ready[w];
            byp_opb_ready[w] = disp_opb_ready[w];
            for (int c = 0; c < NUM_WAYS; c++) begin
                if (!disp_opa_ready[w] && cdb_valid[c]
                        && cdb_tag[c] == prf_idx_t'(disp_opa[w])) begin
                    byp_opa[w]       = cdb_data[c];
                    byp_opa_ready[w] = 1'b1;
                end
                if (!disp_opb_ready[w] && cdb_valid[c]
                        && cdb_tag[c] == prf_idx_t'(disp_opb[w])) begin
                    byp_opb[w]       = cdb_data[c];
                    byp_opb_ready[w] = 1'b1;
                end
            end
        end
    end

    // each loading way, in way order, takes the lowest free entry left
    always_comb begin
        entry_mask_t avail;
        logic        found;
        avail          = entry_free;
        disp_accept    = '0;
        entry_load     = '0;
        load_opa       = '0;
        load_opb       = '0;
        load_opa_ready = '0;
        load_opb_ready = '0;
        load_dest_idx  = '0;
        load_rob_idx   = '0;
        load_pc        = '0;
        load_offset    = '0;
        load_func      = {RS_SIZE{ALU_ADD}};
        load_rd_mem    = '0;
        load_wr_mem    = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            found = 1'b0;
            for (int e = 0; e < RS_SIZE; e++) begin
                if (disp_load[w] && !found && avail[e]) begin
                    found             = 1'b1;
                    avail[e]          = 1'b0;
                    disp_accept[w]    = 1'b1;
                    entry_load[e]     = 1'b1;
                    load_opa[e]       = byp_opa[w];
                    load_opb[e]       = byp_opb[w];
                    load_opa_ready[e] = byp_opa_ready[w];
                    load_opb_ready[e] = byp_opb_ready[w];
                    load_dest_idx[e]  = disp_dest_idx[w];
                    load_rob_idx[e]   = disp_rob_idx[w];
                    load_pc[e]        = disp_pc[w];
                    load_offset[e]    = disp_offset[w];
                    load_func[e]      = disp_func[w];
                    load_rd_mem[e]    = disp_rd_mem[w];
                    load_wr_mem[e]    = disp_wr_mem[w];
                end
            end
        end
    end

    always_comb begin
        accept_count = '0;
        for (int w = 0; w < NUM_WAYS; w++)
            accept_count = accept_count + free_count_t'(disp_accept[w]);
    end

    always_ff @(posedge clock) begin
        if (reset)
            free_count <= free_count_t'(RS_SIZE);
        else
            free_count <= free_count - accept_count + issue_count;
    end

endmodule

// File: rs_entry.sv
module rs_entry (
    input  logic                                        clock,
    input  logic                                        reset,
    input  logic                                        load,
    input  logic                                        issue,
    input  rs_pkg::data_t                               opa_in,
    input  rs_pkg::data_t                               opb_in,
    input  logic                                        opa_ready_in,
    input  logic                                        opb_ready_in,
    input  rs_pkg::prf_idx_t                            dest_idx_in,
    input  rs_pkg::rob_idx_t                            rob_idx_in,
    input  rs_pkg::pc_t                                 pc_in,
    input  rs_pkg::offset_t                             offset_in,
    input  rs_pkg::alu_func_t                           func_in,
    input  logic                                        rd_mem_in,
    input  logic                                        wr_mem_in,
    input  rs_pkg::way_mask_t                           cdb_valid,
    input  rs_pkg::prf_idx_t [rs_pkg::NUM_WAYS-1:0]     cdb_tag,
    input  rs_pkg::data_t [rs_pkg::NUM_WAYS-1:0]        cdb_data,
    output logic                                        is_free,
    output logic                                        ready,
    output rs_pkg::data_t                               opa_out,
    output rs_pkg::data_t                               opb_out,
    output rs_pkg::prf_idx_t                            dest_idx_out,
    output rs_pkg::rob_idx_t                            rob_idx_out,
    output rs_pkg::pc_t                                 pc_out,
    output rs_pkg::offset_t                             offset_out,
    output rs_pkg::alu_func_t                           func_out,
    output logic                                        rd_mem_out,
    output logic                                        wr_mem_out
);
    import rs_pkg::*;

    logic  occupied;
    logic  opa_ready;
    logic  opb_ready;
    logic  opa_ready_next;
    logic  opb_ready_next;
    data_t opa_next;
    data_t opb_next;

    assign is_free = ~occupied;
    assign ready   = occupied & opa_ready & opb_ready;

    // cdb wakeup, later ways override earlier ones
    always_comb begin
        opa_next       = opa_out;
        opb_next       = opb_out;
        opa_ready_next = opa_ready;
        opb_ready_next = opb_ready;
        if (occupied) begin
            for (int c = 0; c < NUM_WAYS; c++) begin
                if (!opa_ready && cdb_valid[c] && cdb_tag[c] == prf_idx_t'(opa_out)) begin
                    opa_next       = cdb_data[c];
                    opa_ready_next = 1'b1;
                end
                if (!opb_ready && cdb_valid[c] && cdb_tag[c] == prf_idx_t'(opb_out)) begin
                    opb_next       = cdb_data[c];
                    opb_ready_next = 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            occupied  <= 1'b0;
            opa_ready <= 1'b0;
            opb_ready <= 1'b0;
        end else if (load) begin
            occupied  <= 1'b1;
            opa_ready <= opa_ready_in;
            opb_ready <= opb_ready_in;
        end else begin
            if (issue)
                occupied <= 1'b0;   // free again after this edge
            opa_ready <= opa_ready_next;
            opb_ready <= opb_ready_next;
        end
    end

    always_ff @(posedge clock) begin
        if (load) begin
            opa_out      <= opa_in;
            opb_out      <= opb_in;
            dest_idx_out <= dest_idx_in;
            rob_idx_out  <= rob_idx_in;
            pc_out       <= pc_in;
            offset_out   <= offset_in;
            func_out     <= func_in;
            rd_mem_out   <= rd_mem_in;
            wr_mem_out   <= wr_mem_in;
        end else begin
            opa_out <= opa_next;
            opb_out <= opb_next;
        end
    end

endmodule

// File: rs_issue_select.sv
module rs_issue_select (
    input  rs_pkg::entry_mask_t                         entry_ready,
    input  rs_pkg::data_t [rs_pkg::RS_SIZE-1:0]         entry_opa,
    input  rs_pkg::data_t [rs_pkg::RS_SIZE-1:0]         entry_opb,
    input  rs_pkg::prf_idx_t [rs_pkg::RS_SIZE-1:0]      entry_dest_idx,
    input  rs_pkg::rob_idx_t [rs_pkg::RS_SIZE-1:0]      entry_rob_idx,
    input  rs_pkg::pc_t [rs_pkg::RS_SIZE-1:0]           entry_pc,
    input  rs_pkg::offset_t [rs_pkg::RS_SIZE-1:0]       entry_offset,
    input  rs_pkg::alu_func_t [rs_pkg::RS_SIZE-1:0]     entry_func,
    input  rs_pkg::entry_mask_t                         entry_rd_mem,
    input  rs_pkg::entry_mask_t                         entry_wr_mem,
    output rs_pkg::entry_mask_t                         entry_issue,
    output rs_pkg::free_count_t                         issue_count,
    output rs_pkg::way_mask_t                           issue_valid,
    output rs_pkg::data_t [rs_pkg::NUM_WAYS-1:0]        issue_opa,
    output rs_pkg::data_t [rs_pkg::NUM_WAYS-1:0]        issue_opb,
    output rs_pkg::prf_idx_t [rs_pkg::NUM_WAYS-1:0]     issue_dest_idx,
    output rs_pkg::rob_idx_t [rs_pkg::NUM_WAYS-1:0]     issue_rob_idx,
    output rs_pkg::pc_t [rs_pkg::NUM_WAYS-1:0]          issue_pc,
    output rs_pkg::offset_t [rs_pkg::NUM_WAYS-1:0]      issue_offset,
    output rs_pkg::alu_func_t [rs_pkg::NUM_WAYS-1:0]    issue_func,
    output rs_pkg::way_mask_t                           issue_rd_mem,
    output rs_pkg::way_mask_t                           issue_wr_mem
);
    import rs_pkg::*;

    // lowest index first, k-th grant goes out on way k
    always_comb begin
        int unsigned k;
        k              = 0;
        entry_issue    = '0;
        issue_valid    = '0;
        issue_opa      = '0;
        issue_opb      = '0;
        issue_dest_idx = '0;
        issue_rob_idx  = '0;
        issue_pc       = '0;
        issue_offset   = '0;
        issue_func     = {NUM_WAYS{ALU_ADD}};
        issue_rd_mem   = '0;
        issue_wr_mem   = '0;
        for (int e = 0; e < RS_SIZE; e++) begin
            if (k < NUM_WAYS && entry_ready[e]) begin
                entry_issue[e]    = 1'b1;
                issue_valid[k]    = 1'b1;
                issue_opa[k]      = entry_opa[e];
                issue_opb[k]      = entry_opb[e];
                issue_dest_idx[k] = entry_dest_idx[e];
                issue_rob_idx[k]  = entry_rob_idx[e];
                issue_pc[k]       = entry_pc[e];
                issue_offset[k]   = entry_offset[e];
                issue_func[k]     = entry_func[e];
                issue_rd_mem[k]   = entry_rd_mem[e];
                issue_wr_mem[k]   = entry_wr_mem[e];
                k++;
            end
        end
        issue_count = free_count_t'(k);   // back to the free counter
    end

endmodule

// File: rs_pkg.sv
package rs_pkg;

    localparam int NUM_WAYS     = 3;   // dispatch, issue and cdb width
    localparam int RS_SIZE      = 16;
    localparam int DATA_WIDTH   = 64;
    localparam int PRF_SIZE     = 64;
    localparam int ROB_SIZE     = 16;
    localparam int PC_WIDTH     = 32;
    localparam int OFFSET_WIDTH = 16;

    // operand value, or a tag in the low bits while not ready
    typedef logic [DATA_WIDTH-1:0]            data_t;
    typedef logic [$clog2(PRF_SIZE)-1:0]      prf_idx_t;
    typedef logic [$clog2(ROB_SIZE)-1:0]      rob_idx_t;
    typedef logic [PC_WIDTH-1:0]              pc_t;
    typedef logic [OFFSET_WIDTH-1:0]          offset_t;
    typedef logic [NUM_WAYS-1:0]              way_mask_t;
    typedef logic [RS_SIZE-1:0]               entry_mask_t;
    typedef logic [$clog2(RS_SIZE + 1)-1:0]   free_count_t;   // must hold RS_SIZE

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SLT
    } alu_func_t;

endpackage

// File: run_sim.sh
#!/bin/sh
# build and run with verilator, then decide from the simulation log
rm -rf obj_dir sim.log
verilator --binary --timing --timescale 1ns/1ns -Wno-fatal \
    --top-module tb_reservation_station -f sources.f -o tb_reservation_station \
    && ./obj_dir/tb_reservation_station > sim.log 2>&1 \
    || { echo "build or simulation failed"; exit 1; }
cat sim.log
grep -q "TEST PASS" sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// File: sources.f
rs_pkg.sv
rs_entry.sv
rs_alloc.sv
rs_issue_select.sv
reservation_station.sv
tb_reservation_station.sv

// File: tb_reservation_station.sv
module tb_reservation_station;
    timeunit 1ns;
    timeprecision 1ns;
    import rs_pkg::*;

    localparam int CLOCK_PERIOD    = 20;
    localparam int RESET_CYCLES    = 10;
    localparam int DIRECTED_CYCLES = 60;
    localparam int RANDOM_CYCLES   = 2000;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES + 200;

    logic                       clock = 1'b0;
    logic                       reset = 1'b1;
    way_mask_t                  disp_load = '0;
    data_t [NUM_WAYS-1:0]       disp_opa = '0;
    data_t [NUM_WAYS-1:0]       disp_opb = '0;
    way_mask_t                  disp_opa_ready = '0;
    way_mask_t                  disp_opb_ready = '0;
    prf_idx_t [NUM_WAYS-1:0]    disp_dest_idx = '0;
    rob_idx_t [NUM_WAYS-1:0]    disp_rob_idx = '0;
    pc_t [NUM_WAYS-1:0]         disp_pc = '0;
    offset_t [NUM_WAYS-1:0]     disp_offset = '0;
    alu_func_t [NUM_WAYS-1:0]   disp_func = {NUM_WAYS{ALU_ADD}};
    way_mask_t                  disp_rd_mem = '0;
    way_mask_t                  disp_wr_mem = '0;
    way_mask_t                  cdb_valid = '0;
    prf_idx_t [NUM_WAYS-1:0]    cdb_tag = '0;
    data_t [NUM_WAYS-1:0]       cdb_data = '0;
    way_mask_t                  disp_accept;
    free_count_t                free_count;
    way_mask_t                  issue_valid;
    data_t [NUM_WAYS-1:0]       issue_opa;
    data_t [NUM_WAYS-1:0]       issue_opb;
    prf_idx_t [NUM_WAYS-1:0]    issue_dest_idx;
    rob_idx_t [NUM_WAYS-1:0]    issue_rob_idx;
    pc_t [NUM_WAYS-1:0]         issue_pc;
    offset_t [NUM_WAYS-1:0]     issue_offset;
    alu_func_t [NUM_WAYS-1:0]   issue_func;
    way_mask_t                  issue_rd_mem;
    way_mask_t                  issue_wr_mem;

    // queue model holding the state after the coming edge
    logic                       m_occ [RS_SIZE];
    logic                       m_ra [RS_SIZE];
    logic                       m_rb [RS_SIZE];
    data_t                      m_opa [RS_SIZE];
    data_t                      m_opb [RS_SIZE];
    logic [63:0]                m_info [RS_SIZE];
    free_count_t                m_free;
    way_mask_t                  exp_accept;
    way_mask_t                  exp_valid;
    free_count_t                exp_free;
    data_t                      exp_opa [NUM_WAYS];
    data_t                      exp_opb [NUM_WAYS];
    logic [63:0]                exp_info [NUM_WAYS];

    integer                     seed = 78;
    int                         checks = 0;
    int                         errors = 0;
    int                         tests = 0;
    int                         test_errors_base = 0;
    string                      current_test = "reset";

    reservation_station reservation_station_inst (.*);

    initial begin
        forever #(CLOCK_PERIOD / 2) clock = ~clock;
    end

    function automatic logic [63:0] disp_info(input int w);
        return {1'b0, disp_dest_idx[w], disp_rob_idx[w], disp_pc[w], disp_offset[w],
                disp_func[w], disp_rd_mem[w], disp_wr_mem[w]};
    endfunction

    function automatic logic [63:0] issue_info(input int w);
        return {1'b0, issue_dest_idx[w], issue_rob_idx[w], issue_pc[w], issue_offset[w],
                issue_func[w], issue_rd_mem[w], issue_wr_mem[w]};
    endfunction

    // a waiting operand takes the data of the highest matching cdb way
    function automatic void snoop(input logic rdy, input data_t val,
                                  output logic rdy_o, output data_t val_o);
        rdy_o = rdy;
        val_o = val;
        for (int c = 0; c < NUM_WAYS; c++) begin
            if (!rdy && cdb_valid[c] && cdb_tag[c] == prf_idx_t'(val)) begin
                rdy_o = 1'b1;
                val_o = cdb_data[c];
            end
        end
    endfunction

    function automatic void model_reset();
        for (int e = 0; e < RS_SIZE; e++)
            m_occ[e] = 1'b0;
        m_free = free_count_t'(RS_SIZE);
    endfunction

    function automatic void model_step();
        entry_mask_t avail;
        entry_mask_t issued;
        int          k;
        int          n_acc;
        int          slot;
        k          = 0;
        n_acc      = 0;
        exp_valid  = '0;
        exp_accept = '0;
        exp_free   = m_free;
        for (int w = 0; w < NUM_WAYS; w++) begin
            exp_opa[w]  = '0;
            exp_opb[w]  = '0;
            exp_info[w] = '0;
        end
        for (int e = 0; e < RS_SIZE; e++) begin
            avail[e]  = !m_occ[e];
            issued[e] = m_occ[e] && m_ra[e] && m_rb[e] && k < NUM_WAYS;
            if (issued[e]) begin   // lowest index first
                exp_valid[k] = 1'b1;
                exp_opa[k]   = m_opa[e];
                exp_opb[k]   = m_opb[e];
                exp_info[k]  = m_info[e];
                k++;
            end
        end
        for (int e = 0; e < RS_SIZE; e++) begin
            if (m_occ[e]) begin
                snoop(m_ra[e], m_opa[e], m_ra[e], m_opa[e]);
                snoop(m_rb[e], m_opb[e], m_rb[e], m_opb[e]);
            end
            if (issued[e])
                m_occ[e] = 1'b0;
        end
        for (int w = 0; w < NUM_WAYS; w++) begin
            slot = -1;
            for (int e = RS_SIZE - 1; e >= 0; e--)
                if (avail[e])
                    slot = e;
            if (disp_load[w] && slot >= 0) begin
                avail[slot]   = 1'b0;
                exp_accept[w] = 1'b1;
                n_acc++;
                m_occ[slot]   = 1'b1;
                m_info[slot]  = disp_info(w);
                snoop(disp_opa_ready[w], disp_opa[w], m_ra[slot], m_opa[slot]);   // bypass
                snoop(disp_opb_ready[w], disp_opb[w], m_rb[slot], m_opb[slot]);
            end
        end
        m_free = m_free - free_count_t'(n_acc) + free_count_t'(k);
    endfunction

    task automatic check(input string what, input logic [63:0] expected,
                         input logic [63:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("Mismatch %s %s: expected %0h, actual %0h",
                     current_test, what, expected, actual);
        end
    endtask

    always @(negedge clock) begin
        if (reset) begin
            model_reset();
        end else begin
            model_step();
            check("disp_accept", exp_accept, disp_accept);
            check("free_count", exp_free, free_count);
            check("issue_valid", exp_valid, issue_valid);
            for (int w = 0; w < NUM_WAYS; w++) begin
                check($sformatf("issue_opa[%0d]", w), exp_opa[w], issue_opa[w]);
                check($sformatf("issue_opb[%0d]", w), exp_opb[w], issue_opb[w]);
                check($sformatf("issue fields[%0d]", w), exp_info[w], issue_info(w));
            end
        end
    end

    task automatic begin_test(input string name);
        current_test     = name;
        test_errors_base = errors;
    endtask

    task automatic finish_test();
        @(posedge clock);   // past the last compare of the test
        tests++;
        $display("%s done, %0d errors", current_test, errors - test_errors_base);
    endtask

    task automatic clear_inputs();
        disp_load <= '0;
        cdb_valid <= '0;
    endtask

    task automatic load_way(input int w, input data_t a, input logic ra,
                            input data_t b, input logic rb);
        disp_load[w]      <= 1'b1;
        disp_opa[w]       <= a;
        disp_opa_ready[w] <= ra;
        disp_opb[w]       <= b;
        disp_opb_ready[w] <= rb;
        disp_dest_idx[w]  <= prf_idx_t'($random(seed));
        disp_rob_idx[w]   <= rob_idx_t'($random(seed));
        disp_pc[w]        <= pc_t'($random(seed));
        disp_offset[w]    <= offset_t'($random(seed));
        disp_func[w]      <= alu_func_t'(3'($random(seed)));
        disp_rd_mem[w]    <= 1'($random(seed));
        disp_wr_mem[w]    <= 1'($random(seed));
    endtask

    task automatic broadcast(input int w, input prf_idx_t tag, input data_t value);
        cdb_valid[w] <= 1'b1;
        cdb_tag[w]   <= tag;
        cdb_data[w]  <= value;
    endtask

    task automatic random_cycle();
        data_t a;
        data_t b;
        @(posedge clock);
        for (int w = 0; w < NUM_WAYS; w++) begin
            a      = {$random(seed), $random(seed)};
            b      = {$random(seed), $random(seed)};
            a[5:3] = '0;   // tags 0 to 7 so waiting entries wake up
            b[5:3] = '0;
            load_way(w, a, 1'($random(seed)), b, 1'($random(seed)));
            disp_load[w] <= 1'($random(seed));
            cdb_valid[w] <= 1'($random(seed));
            cdb_tag[w]   <= prf_idx_t'($random(seed) & 7);
            cdb_data[w]  <= {$random(seed), $random(seed)};
        end
    endtask

    task automatic wait_free(input int target, input int limit);
        int n;
        n = 0;
        @(negedge clock);
        while (free_count != free_count_t'(target) && n < limit) begin
            @(negedge clock);
            n++;
        end
        if (free_count != free_count_t'(target)) begin
            errors++;
            $display("%s: free_count did not reach %0d within %0d cycles",
                     current_test, target, limit);
        end
    endtask

    initial begin
        repeat (RESET_CYCLES) @(posedge clock);
        reset <= 1'b0;

        begin_test("reset");
        @(negedge clock);
        check("free_count", RS_SIZE, free_count);
        check("issue_valid", 0, issue_valid);
        check("disp_accept", 0, disp_accept);
        finish_test();

        begin_test("ready_dispatch");
        @(posedge clock);
        for (int w = 0; w < NUM_WAYS; w++)
            load_way(w, {$random(seed), $random(seed)}, 1'b1,
                     {$random(seed), $random(seed)}, 1'b1);
        @(posedge clock);
        clear_inputs();
        @(negedge clock);
        check("issue_valid", 3'b111, issue_valid);
        for (int w = 0; w < NUM_WAYS; w++) begin
            check("issue_opa", disp_opa[w], issue_opa[w]);
            check("issue_opb", disp_opb[w], issue_opb[w]);
            check("issue fields", disp_info(w), issue_info(w));
        end
        finish_test();

        begin_test("two_tags");
        @(posedge clock);
        load_way(0, data_t'(5), 1'b0, data_t'(9), 1'b0);
        @(posedge clock);
        clear_inputs();
        broadcast(1, 6'd5, 64'h1111_2222_3333_4444);
        @(posedge clock);
        clear_inputs();
        broadcast(2, 6'd9, 64'h5555_6666_7777_8888);
        @(negedge clock);
        check("issue_valid", 0, issue_valid);   // second tag not captured yet
        @(posedge clock);
        clear_inputs();
        @(negedge clock);
        check("issue_valid", 3'b001, issue_valid);
        check("issue_opa", 64'h1111_2222_3333_4444, issue_opa[0]);
        check("issue_opb", 64'h5555_6666_7777_8888, issue_opb[0]);
        finish_test();

        begin_test("dispatch_bypass");
        @(posedge clock);
        load_way(0, data_t'(12), 1'b0, data_t'(77), 1'b1);
        broadcast(0, 6'd12, 64'hdead_beef_0bad_f00d);
        @(posedge clock);
        clear_inputs();
        @(negedge clock);
        check("issue_valid", 3'b001, issue_valid);
        check("issue_opa", 64'hdead_beef_0bad_f00d, issue_opa[0]);
        finish_test();

        begin_test("fill_and_drain");
        @(posedge clock);
        for (int w = 0; w < NUM_WAYS; w++)
            load_way(w, data_t'(40), 1'b0, data_t'(w), 1'b1);
        wait_free(0, 10);
        check("disp_accept", 0, disp_accept);
        @(posedge clock);
        clear_inputs();
        broadcast(0, 6'd40, 64'h0123_4567_89ab_cdef);   // wakes all sixteen
        @(posedge clock);
        clear_inputs();
        wait_free(RS_SIZE, 20);
        finish_test();

        begin_test("random_stream");
        repeat (RANDOM_CYCLES) random_cycle();
        @(posedge clock);
        clear_inputs();
        @(negedge clock);
        finish_test();

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLOCK_PERIOD);
        $display("timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("TEST FAIL");
        $finish;
    end

endmodule
